//--- decoder_consts.svh
`ifndef DECODER_CONSTS_SVH
`define DECODER_CONSTS_SVH

`define XLEN            32
`define REG_ADDR_WIDTH  5

// Major opcodes in inst[6:0]
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011

`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

`define F3_LB    3'b000
`define F3_LH    3'b001
`define F3_LW    3'b010
`define F3_LBU   3'b100
`define F3_LHU   3'b101

`define F3_SB    3'b000
`define F3_SH    3'b001
`define F3_SW    3'b010

// Shared by OP and OP-IMM
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SRL   3'b101
`define F3_OR    3'b110
`define F3_AND   3'b111

`endif

//--- decoder_pkg.sv
package decoder_pkg;

    // Numeric values fixed for the op index in the trace
    typedef enum logic [5:0] {
        OP_ILLEGAL = 6'd0,
        OP_LUI     = 6'd1,
        OP_AUIPC   = 6'd2,
        OP_JAL     = 6'd3,
        OP_JALR    = 6'd4,
        OP_BEQ     = 6'd5,
        OP_BNE     = 6'd6,
        OP_BLT     = 6'd7,
        OP_BGE     = 6'd8,
        OP_BLTU    = 6'd9,
        OP_BGEU    = 6'd10,
        OP_LB      = 6'd11,
        OP_LH      = 6'd12,
        OP_LW      = 6'd13,
        OP_LBU     = 6'd14,
        OP_LHU     = 6'd15,
        OP_SB      = 6'd16,
        OP_SH      = 6'd17,
        OP_SW      = 6'd18,
        OP_ADDI    = 6'd19,
        OP_SLTI    = 6'd20,
        OP_SLTIU   = 6'd21,
        OP_XORI    = 6'd22,
        OP_ORI     = 6'd23,
        OP_ANDI    = 6'd24,
        OP_SLLI    = 6'd25,
        OP_SRLI    = 6'd26,
        OP_SRAI    = 6'd27,
        OP_ADD     = 6'd28,
        OP_SUB     = 6'd29,
        OP_SLL     = 6'd30,
        OP_SLT     = 6'd31,
        OP_SLTU    = 6'd32,
        OP_XOR     = 6'd33,
        OP_SRL     = 6'd34,
        OP_SRA     = 6'd35,
        OP_OR      = 6'd36,
        OP_AND     = 6'd37
    } inst_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,   // R-type and illegal
        IMM_I,
        IMM_SHAMT,  // Shift amount only
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    typedef enum logic [1:0] {
        UNIT_ROB_ONLY,
        UNIT_LSB,
        UNIT_RS
    } dispatch_unit_e;

endpackage

//--- decode_if.sv
`include "decoder_consts.svh"

interface decode_if;
    import decoder_pkg::*;

    logic                       valid;
    inst_op_e                   op;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`XLEN-1:0]           imm;
    logic [`XLEN-1:0]           inst_addr;
    logic                       jump_pred;
    logic                       hold;       // Stage two stalled

    modport producer (
        output valid,
        output op,
        output rd,
        output rs1,
        output rs2,
        output imm,
        output inst_addr,
        output jump_pred,
        input  hold
    );

    modport consumer (
        input  valid,
        input  op,
        input  rd,
        input  rs1,
        input  rs2,
        input  imm,
        input  inst_addr,
        input  jump_pred,
        output hold
    );

endinterface

//--- op_decode.sv
`include "decoder_consts.svh"

module op_decode (
    input  logic [`XLEN-1:0]      inst,
    output decoder_pkg::inst_op_e op,
    output decoder_pkg::imm_fmt_e imm_fmt
);
    import decoder_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;    // funct7 bit 30

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    always_comb begin
        op      = OP_ILLEGAL;
        imm_fmt = IMM_NONE;
        case (opcode)
            `OPC_LUI: begin
                op      = OP_LUI;
                imm_fmt = IMM_U;
            end
            `OPC_AUIPC: begin
                op      = OP_AUIPC;
                imm_fmt = IMM_U;
            end
            `OPC_JAL: begin
                op      = OP_JAL;
                imm_fmt = IMM_J;
            end
            `OPC_JALR: begin
                op      = OP_JALR;
                imm_fmt = IMM_I;
            end
            `OPC_BRANCH: begin
                imm_fmt = IMM_B;
                case (funct3)
                    `F3_BEQ:  op = OP_BEQ;
                    `F3_BNE:  op = OP_BNE;
                    `F3_BLT:  op = OP_BLT;
                    `F3_BGE:  op = OP_BGE;
                    `F3_BLTU: op = OP_BLTU;
                    `F3_BGEU: op = OP_BGEU;
                    default:  op = OP_ILLEGAL;
                endcase
            end
            `OPC_LOAD: begin
                imm_fmt = IMM_I;
                case (funct3)
                    `F3_LB:  op = OP_LB;
                    `F3_LH:  op = OP_LH;
                    `F3_LW:  op = OP_LW;
                    `F3_LBU: op = OP_LBU;
                    `F3_LHU: op = OP_LHU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            `OPC_STORE: begin
                imm_fmt = IMM_S;
                case (funct3)
                    `F3_SB:  op = OP_SB;
                    `F3_SH:  op = OP_SH;
                    `F3_SW:  op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end
            `OPC_OP_IMM: begin
                imm_fmt = IMM_I;
                case (funct3)
                    `F3_ADD:  op = OP_ADDI;
                    `F3_SLT:  op = OP_SLTI;
                    `F3_SLTU: op = OP_SLTIU;
                    `F3_XOR:  op = OP_XORI;
                    `F3_OR:   op = OP_ORI;
                    `F3_AND:  op = OP_ANDI;
                    `F3_SLL: begin
                        op      = OP_SLLI;
                        imm_fmt = IMM_SHAMT;
                    end
                    default: begin  // Right shifts
                        op      = alt ? OP_SRAI : OP_SRLI;
                        imm_fmt = IMM_SHAMT;
                    end
                endcase
            end
            `OPC_OP: begin
                case (funct3)
                    `F3_ADD:  op = alt ? OP_SUB : OP_ADD;
                    `F3_SLL:  op = OP_SLL;
                    `F3_SLT:  op = OP_SLT;
                    `F3_SLTU: op = OP_SLTU;
                    `F3_XOR:  op = OP_XOR;
                    `F3_SRL:  op = alt ? OP_SRA : OP_SRL;
                    `F3_OR:   op = OP_OR;
                    default:  op = OP_AND;
                endcase
            end
            default: op = OP_ILLEGAL;
        endcase

        if (op == OP_ILLEGAL) begin
            imm_fmt = IMM_NONE;  // Unused funct3 within a known opcode
        end
    end

endmodule

//--- imm_gen.sv
`include "decoder_consts.svh"

module imm_gen (
    input  logic [`XLEN-1:0]      inst,
    input  decoder_pkg::imm_fmt_e imm_fmt,
    output logic [`XLEN-1:0]      imm
);
    import decoder_pkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{(`XLEN-12){sign}}, inst[31:20]};
            end
            IMM_SHAMT: begin
                imm = {{(`XLEN-5){1'b0}}, inst[24:20]};
            end
            IMM_S: begin
                imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{(`XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            IMM_J: begin
                // imm[20|10:1|11|19:12] in the encoding
                imm = {{(`XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- inst_decode.sv
`include "decoder_consts.svh"

module inst_decode (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             fet_valid,
    input  logic [`XLEN-1:0] fet_inst,
    input  logic [`XLEN-1:0] fet_inst_addr,
    input  logic             fet_jump_pred,
    decode_if.producer       out
);
    import decoder_pkg::*;

    inst_op_e         op;
    imm_fmt_e         imm_fmt;
    logic [`XLEN-1:0] imm;
    logic             use_rd;
    logic             use_rs1;
    logic             use_rs2;

    op_decode u_op_decode (
        .inst    (fet_inst),
        .op      (op),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm_gen (
        .inst    (fet_inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // Which register fields the format carries
    always_comb begin
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (imm_fmt)
            IMM_NONE: begin  // R-type, or illegal
                use_rd  = (op != OP_ILLEGAL);
                use_rs1 = (op != OP_ILLEGAL);
                use_rs2 = (op != OP_ILLEGAL);
            end
            IMM_I, IMM_SHAMT: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            IMM_S, IMM_B: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: use_rd = 1'b1;  // U and J
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out.valid <= 1'b0;
        end else if (!out.hold) begin
            out.valid <= fet_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!out.hold) begin
            out.op        <= op;
            out.rd        <= use_rd ? fet_inst[11:7] : '0;
            out.rs1       <= use_rs1 ? fet_inst[19:15] : '0;
            out.rs2       <= use_rs2 ? fet_inst[24:20] : '0;
            out.imm       <= imm;
            out.inst_addr <= fet_inst_addr;
            out.jump_pred <= fet_jump_pred;
        end
    end

    // Stage two stall freezes the item waiting in stage one
    a_hold_keeps_item: assert property (@(posedge clk) disable iff (reset)
        out.hold && !flush |=> $stable(out.valid) && $stable(out.op) &&
            $stable(out.imm) && $stable(out.inst_addr) && $stable(out.rd) &&
            $stable(out.rs1) && $stable(out.rs2) && $stable(out.jump_pred));

endmodule

//--- dispatch_stage.sv
`include "decoder_consts.svh"

module dispatch_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             lsb_full,
    input  logic                             rob_full,
    input  logic                             rs_full,
    decode_if.consumer                       in,
    output logic                             stall,
    output logic                             dec_valid,
    output decoder_pkg::inst_op_e            dec_op,
    output logic                             dec_jump_pred,
    output logic [`REG_ADDR_WIDTH-1:0]       dec_rd,
    output logic [`REG_ADDR_WIDTH-1:0]       dec_rs1,
    output logic [`REG_ADDR_WIDTH-1:0]       dec_rs2,
    output logic [`XLEN-1:0]                 dec_imm,
    output logic [`XLEN-1:0]                 dec_inst_addr
);
    import decoder_pkg::*;

    dispatch_unit_e unit;

    always_comb begin
        case (dec_op)
            OP_LUI, OP_AUIPC, OP_JAL: unit = UNIT_ROB_ONLY;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW:      unit = UNIT_LSB;
            default:                  unit = UNIT_RS;  // Includes illegal
        endcase
    end

    always_comb begin
        case (unit)
            UNIT_ROB_ONLY: stall = dec_valid && rob_full;
            UNIT_LSB:      stall = dec_valid && (rob_full || lsb_full);
            default:       stall = dec_valid && (rob_full || rs_full);
        endcase
    end

    assign in.hold = stall;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_op        <= in.op;
            dec_rd        <= in.rd;
            dec_rs1       <= in.rs1;
            dec_rs2       <= in.rs2;
            dec_imm       <= in.imm;
            dec_inst_addr <= in.inst_addr;
            dec_jump_pred <= in.jump_pred;
        end
    end

    a_stall_keeps_valid: assert property (@(posedge clk) disable iff (reset)
        stall && !flush |=> dec_valid);

    a_stall_keeps_outputs: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(dec_op) && $stable(dec_rd) && $stable(dec_rs1) &&
            $stable(dec_rs2) && $stable(dec_imm) && $stable(dec_inst_addr) &&
            $stable(dec_jump_pred));

endmodule

//--- decoder_top.sv
`include "decoder_consts.svh"

module decoder_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       fet_valid,
    input  logic [`XLEN-1:0]           fet_inst,
    input  logic [`XLEN-1:0]           fet_inst_addr,
    input  logic                       fet_jump_pred,
    input  logic                       lsb_full,
    input  logic                       rob_full,
    input  logic                       rs_full,
    output logic                       stall,
    output logic                       dec_valid,
    output decoder_pkg::inst_op_e      dec_op,
    output logic                       dec_jump_pred,
    output logic [`REG_ADDR_WIDTH-1:0] dec_rd,
    output logic [`REG_ADDR_WIDTH-1:0] dec_rs1,
    output logic [`REG_ADDR_WIDTH-1:0] dec_rs2,
    output logic [`XLEN-1:0]           dec_imm,
    output logic [`XLEN-1:0]           dec_inst_addr
);

    decode_if stage_bus ();  // Stage one to stage two

    inst_decode u_inst_decode (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .fet_valid     (fet_valid),
        .fet_inst      (fet_inst),
        .fet_inst_addr (fet_inst_addr),
        .fet_jump_pred (fet_jump_pred),
        .out           (stage_bus)
    );

    dispatch_stage u_dispatch_stage (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .lsb_full      (lsb_full),
        .rob_full      (rob_full),
        .rs_full       (rs_full),
        .in            (stage_bus),
        .stall         (stall),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_jump_pred (dec_jump_pred),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_imm       (dec_imm),
        .dec_inst_addr (dec_inst_addr)
    );

endmodule

//--- tb_decoder.sv
`include "decoder_consts.svh"

module tb_decoder;
    import decoder_pkg::*;

    localparam int TRACE_LEN   = 25;
    localparam int FIELDS      = 8;
    localparam int CYCLE_LIMIT = 20 * TRACE_LEN + 100;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       flush;
    logic                       fet_valid;
    logic [`XLEN-1:0]           fet_inst;
    logic [`XLEN-1:0]           fet_inst_addr;
    logic                       fet_jump_pred;
    logic                       lsb_full;
    logic                       rob_full;
    logic                       rs_full;
    logic                       stall;
    logic                       dec_valid;
    inst_op_e                   dec_op;
    logic                       dec_jump_pred;
    logic [`REG_ADDR_WIDTH-1:0] dec_rd;
    logic [`REG_ADDR_WIDTH-1:0] dec_rs1;
    logic [`REG_ADDR_WIDTH-1:0] dec_rs2;
    logic [`XLEN-1:0]           dec_imm;
    logic [`XLEN-1:0]           dec_inst_addr;

    logic [31:0] trace_mem [0:TRACE_LEN*FIELDS-1];
    int          exp_q[$];      // Trace indices in flight in age order
    int          cur_idx = 0;
    int          seed = 10836;
    int          cycle_count = 0;
    int          out_count = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    decoder_top u_decoder_top (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .fet_valid     (fet_valid),
        .fet_inst      (fet_inst),
        .fet_inst_addr (fet_inst_addr),
        .fet_jump_pred (fet_jump_pred),
        .lsb_full      (lsb_full),
        .rob_full      (rob_full),
        .rs_full       (rs_full),
        .stall         (stall),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_jump_pred (dec_jump_pred),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_imm       (dec_imm),
        .dec_inst_addr (dec_inst_addr)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // Queue that the operation goes to decides which flags block it
    function automatic logic expected_stall(input inst_op_e op, input logic valid);
        logic busy;
        case (op)
            OP_LUI, OP_AUIPC, OP_JAL: busy = rob_full;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW:      busy = rob_full || lsb_full;
            default:                  busy = rob_full || rs_full;
        endcase
        return valid && busy;
    endfunction

    task automatic set_full_flags(input logic back_pressure);
        logic [31:0] r;
        r = $random(seed);
        rob_full = back_pressure && (r[1:0] == 2'b00);
        lsb_full = back_pressure && (r[3:2] == 2'b00);
        rs_full  = back_pressure && (r[5:4] == 2'b00);
    endtask

    // Holds the entry on the fetch port until a rising edge without stall
    task automatic send_entry(input int idx, input logic back_pressure);
        logic taken;
        taken = 1'b0;
        @(negedge clk);
        cur_idx       = idx;
        fet_valid     = 1'b1;
        fet_inst      = trace_mem[idx*FIELDS];
        fet_inst_addr = trace_mem[idx*FIELDS + 1];
        fet_jump_pred = trace_mem[idx*FIELDS + 2][0];
        while (!taken) begin
            set_full_flags(back_pressure);
            @(posedge clk);
            taken = !stall;
            if (!taken) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic compare_output(input int idx);
        int base;
        base = idx * FIELDS;
        check_value("dec_op", {26'b0, dec_op}, trace_mem[base + 3]);
        check_value("dec_rd", {27'b0, dec_rd}, trace_mem[base + 4]);
        check_value("dec_rs1", {27'b0, dec_rs1}, trace_mem[base + 5]);
        check_value("dec_rs2", {27'b0, dec_rs2}, trace_mem[base + 6]);
        check_value("dec_imm", dec_imm, trace_mem[base + 7]);
        check_value("dec_inst_addr", dec_inst_addr, trace_mem[base + 1]);
        check_value("dec_jump_pred", {31'b0, dec_jump_pred}, trace_mem[base + 2]);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Scoreboard on pre-edge values
    always @(posedge clk) begin
        if (!reset) begin
            check_value("stall", {31'b0, stall},
                        {31'b0, expected_stall(dec_op, dec_valid)});
            if (flush) begin
                exp_q.delete();  // Both stages killed
            end else begin
                if (dec_valid && !stall) begin
                    out_count++;
                    assert (exp_q.size() != 0) else begin
                        $display("An output appeared with no instruction in flight");
                        other_errors++;
                    end
                    if (exp_q.size() != 0) begin
                        compare_output(exp_q.pop_front());
                    end
                end
                if (fet_valid && !stall) begin
                    exp_q.push_back(cur_idx);
                end
            end
        end
    end

    initial begin
        reset         = 1'b1;
        flush         = 1'b0;
        fet_valid     = 1'b0;
        fet_inst      = '0;
        fet_inst_addr = '0;
        fet_jump_pred = 1'b0;
        lsb_full      = 1'b0;
        rob_full      = 1'b0;
        rs_full       = 1'b0;
        $readmemh("decoder_trace.txt", trace_mem);

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        check_value("dec_valid", {31'b0, dec_valid}, 32'h0);
        check_value("stall", {31'b0, stall}, 32'h0);

        for (int i = 0; i < TRACE_LEN; i++) begin
            send_entry(i, 1'b1);
        end
        @(negedge clk);
        fet_valid = 1'b0;
        while (exp_q.size() != 0) begin
            set_full_flags(1'b1);
            @(negedge clk);
        end
        set_full_flags(1'b0);
        repeat (2) @(negedge clk);  // Both stages empty out within two cycles
        check_value("out_count", out_count, TRACE_LEN);

        // Flush with two instructions in flight
        send_entry(0, 1'b0);
        send_entry(1, 1'b0);
        @(negedge clk);
        fet_valid = 1'b0;
        flush     = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (4) begin
            @(posedge clk);
            assert (!dec_valid) else begin
                $display("dec_valid went high after the flush with no new instruction");
                other_errors++;
            end
        end
        send_entry(2, 1'b0);
        @(negedge clk);
        fet_valid = 1'b0;
        @(posedge clk);
        assert (!dec_valid) else begin
            $display("The instruction after the flush came out one cycle early");
            other_errors++;
        end
        @(posedge clk);
        assert (dec_valid) else begin
            $display("The instruction after the flush was not out two cycles after it was taken");
            other_errors++;
        end
        @(negedge clk);
        check_value("out_count", out_count, TRACE_LEN + 1);

        $display("Errors: %0d value, %0d other, %0d outputs checked",
                 value_errors, other_errors, out_count);
        if (value_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- decoder_trace.txt
// instruction address jump_pred op rd rs1 rs2 imm, all in hex
// op is the index of the decoded operation, 00 is OP_ILLEGAL
123452B7 00001000 0 01 05 00 00 12345000
FFFFF517 00001004 0 02 0A 00 00 FFFFF000
FF9FF0EF 00001008 1 03 01 00 00 FFFFFFF8
347121EF 0000100C 0 03 03 00 00 00012B46
FFC300E7 00001010 1 04 01 06 00 FFFFFFFC
FEC598E3 00001014 1 06 00 0B 0C FFFFFFF0
23FA76E3 00001018 0 0A 00 14 1F 00000A2C
00812383 0000101C 0 0D 07 02 00 00000008
FFF44483 00001020 0 0E 09 08 00 FFFFFFFF
FEF71623 00001024 0 11 00 0E 0F FFFFFFEC
7A21A223 00001028 0 12 00 03 02 000007A4
12318893 0000102C 0 13 11 03 00 00000123
8002C213 00001030 0 16 04 05 00 FFFFF800
0013B313 00001034 0 15 06 07 00 00000001
01F49413 00001038 0 19 08 09 00 0000001F
4075D513 0000103C 0 1B 0A 0B 00 00000007
0036D613 00001040 0 1A 0C 0D 00 00000003
003100B3 00001044 0 1C 01 02 03 00000000
41DF0FB3 00001048 0 1D 1F 1E 1D 00000000
407352B3 0000104C 0 23 05 06 07 00000000
016AFA33 00001050 0 25 14 15 16 00000000
FEC5A8E3 00001054 1 00 00 00 00 00000000
00813383 00001058 0 00 00 00 00 00000000
7A21B223 0000105C 0 00 00 00 00 00000000
FFFFFFFF 00001060 0 00 00 00 00 00000000

//--- flist.f
+incdir+.
decoder_pkg.sv
decode_if.sv
op_decode.sv
imm_gen.sv
inst_decode.sv
dispatch_stage.sv
decoder_top.sv
tb_decoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decoder
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
